// File: Makefile
# Verilator build and run for the bus testbench

VERILATOR ?= verilator
TOP ?= bus_tb
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG) || ! grep -q "Regression passed" $(LOG); then \
		echo "simulation reported failure"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/burst_engine.sv
/* burst engine */

`timescale 1ns/1ps
`default_nettype none

module burst_engine (
	input logic clk,
	input logic arst_n,
	input logic start,
	input bus_pkg::bus_cmd_t start_cmd,
	input logic owner,
	output logic busy,
	output bus_pkg::bus_beat_t beat,
	output logic beat_valid,
	input logic ack,
	input logic [bus_pkg::data_w-1:0] rdata,
	input logic bad_sel,
	output bus_pkg::bus_result_t [1:0] result
);

	import bus_pkg::*;

	// control state
	logic busy_q;
	logic owner_q;
	logic beat_valid_q;
	logic [burst_w-1:0] left_q;
	logic err_q;
	bus_result_t [1:0] result_q;

	// latched command payload
	logic wr_q;
	logic [slave_sel_w-1:0] sel_q;
	logic [data_w-1:0] fill_q;
	logic [addr_w-1:0] addr_q;

	// beat accepted by the slave side
	logic beat_ack;
	logic last_ack;

	assign beat_ack = busy_q & ack;
	assign last_ack = beat_ack & (left_q == '0);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy_q <= 1'b0;
			owner_q <= 1'b0;
			beat_valid_q <= 1'b0;
			left_q <= '0;
			err_q <= 1'b0;
		end else begin
			// beat_valid is a single cycle pulse
			beat_valid_q <= 1'b0;
			if (start) begin
				busy_q <= 1'b1;
				owner_q <= owner;
				beat_valid_q <= 1'b1;
				left_q <= start_cmd.burst;
				err_q <= 1'b0;
			end else if (beat_ack) begin
				// sticky over the whole burst
				err_q <= err_q | bad_sel;
				if (left_q == '0) begin
					busy_q <= 1'b0;
				end else begin
					left_q <= left_q - 1'b1;
					// next beat the cycle after the ack
					beat_valid_q <= 1'b1;
				end
			end
		end
	end

	// address steps by one, wraps at 4096 by width
	always_ff @(posedge clk) begin
		if (start) begin
			wr_q <= start_cmd.write;
			sel_q <= start_cmd.slave;
			fill_q <= start_cmd.data;
			addr_q <= start_cmd.addr;
		end else if (beat_ack) begin
			addr_q <= addr_q + 1'b1;
		end
	end

	// results registered one cycle after the ack
	// only the owner's slot is ever nonzero
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			result_q <= '0;
		end else begin
			result_q <= '0;
			if (beat_ack) begin
				result_q[owner_q].rvalid <= ~wr_q;
				result_q[owner_q].rdata <= wr_q ? '0 : rdata;
				result_q[owner_q].done <= last_ack;
				result_q[owner_q].err <= err_q | bad_sel;
			end
		end
	end

	// write bursts fill the range with one byte
	assign beat.write = wr_q;
	assign beat.slave = sel_q;
	assign beat.addr = addr_q;
	assign beat.data = fill_q;

	assign beat_valid = beat_valid_q;
	assign busy = busy_q;
	assign result = result_q;

endmodule

`default_nettype wire

// File: design/bus_arbiter.sv
/* round robin master arbiter */

`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
	input logic clk,
	input logic arst_n,
	input logic [1:0] cmd_valid,
	input bus_pkg::bus_cmd_t [1:0] cmd,
	input logic busy,
	output logic [1:0] cmd_ready,
	output logic start,
	output bus_pkg::bus_cmd_t start_cmd,
	output logic owner
);

	// index of the master granted last
	logic last_grant;
	logic pick;

	// both pending: take the other one
	// one pending: take that one
	always_comb begin
		if (cmd_valid == 2'b11) begin
			pick = ~last_grant;
		end else begin
			pick = cmd_valid[1];
		end
	end

	// grant only while the engine is idle
	assign start = ~busy & (|cmd_valid);

	// one-hot ready, same cycle as start
	always_comb begin
		cmd_ready = 2'b00;
		if (start) begin
			cmd_ready[pick] = 1'b1;
		end
	end

	// command and owner go straight to the engine
	assign start_cmd = cmd[pick];
	assign owner = pick;

	// reset value makes master 1 (index 0) win the first tie
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			last_grant <= 1'b1;
		end else if (start) begin
			last_grant <= pick;
		end
	end

endmodule

`default_nettype wire

// File: design/bus_pkg.sv
/* shared bus types and constants */

`default_nettype none

package bus_pkg;

	// address width inside one slave, 4 KiB each
	localparam int addr_w = 12;
	localparam int data_w = 8;

	// slave select, 0..2 mapped, 3 unmapped
	localparam int slave_sel_w = 2;
	localparam int num_slaves = 3;
	localparam logic [slave_sel_w-1:0] sel_unmapped = 2'd3;

	// burst field n means n+1 beats
	localparam int burst_w = 4;

	// wait states per slave, stands in for the slave delay input
	localparam int slave_wait [0:num_slaves-1] = '{0, 1, 3};
	localparam int wait_cnt_w = 4;

	// read data returned for an unmapped select
	localparam logic [data_w-1:0] err_data = 8'hff;

	// master command, 27 bits
	typedef struct packed {
		logic write;
		logic [slave_sel_w-1:0] slave;
		logic [addr_w-1:0] addr;
		logic [burst_w-1:0] burst;
		logic [data_w-1:0] data;
	} bus_cmd_t;

	// single slave access, 23 bits
	typedef struct packed {
		logic write;
		logic [slave_sel_w-1:0] slave;
		logic [addr_w-1:0] addr;
		logic [data_w-1:0] data;
	} bus_beat_t;

	// per master result, 11 bits
	typedef struct packed {
		logic rvalid;
		logic [data_w-1:0] rdata;
		logic done;
		logic err;
	} bus_result_t;

endpackage

`default_nettype wire

// File: design/bus_top.sv
/* two master three slave bus */

`timescale 1ns/1ps
`default_nettype none

module bus_top (
	input logic clk,
	input logic arst_n,
	input logic [1:0] cmd_valid,
	input bus_pkg::bus_cmd_t [1:0] cmd,
	output logic [1:0] cmd_ready,
	output bus_pkg::bus_result_t [1:0] result
);

	import bus_pkg::*;

	// arbiter to engine
	logic start;
	bus_cmd_t start_cmd;
	logic owner;
	logic busy;

	// engine to decoder
	bus_beat_t beat;
	logic beat_valid;
	logic ack;
	logic [data_w-1:0] rdata;
	logic bad_sel;

	// decoder to slaves
	logic [num_slaves-1:0] sel;
	logic [num_slaves-1:0] slave_ack;
	logic [num_slaves-1:0][data_w-1:0] slave_rdata;

	bus_arbiter arbiter0 (
		.clk(clk),
		.arst_n(arst_n),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.busy(busy),
		.cmd_ready(cmd_ready),
		.start(start),
		.start_cmd(start_cmd),
		.owner(owner)
	);

	burst_engine engine0 (
		.clk(clk),
		.arst_n(arst_n),
		.start(start),
		.start_cmd(start_cmd),
		.owner(owner),
		.busy(busy),
		.beat(beat),
		.beat_valid(beat_valid),
		.ack(ack),
		.rdata(rdata),
		.bad_sel(bad_sel),
		.result(result)
	);

	slave_decoder decoder0 (
		.beat(beat),
		.beat_valid(beat_valid),
		.clk(clk),
		.arst_n(arst_n),
		.sel(sel),
		.slave_ack(slave_ack),
		.slave_rdata(slave_rdata),
		.ack(ack),
		.rdata(rdata),
		.bad_sel(bad_sel)
	);

	// slaves differ only in wait states
	for (genvar i = 0; i < num_slaves; i++) begin : g_slave
		ram_slave #(
			.wait_states(slave_wait[i])
		) ram0 (
			.clk(clk),
			.arst_n(arst_n),
			.sel(sel[i]),
			.beat(beat),
			.ack(slave_ack[i]),
			.rdata(slave_rdata[i])
		);
	end

endmodule

`default_nettype wire

// File: design/ram_slave.sv
/* 4 KiB byte RAM slave */

`timescale 1ns/1ps
`default_nettype none

module ram_slave #(
	parameter int wait_states = 0
) (
	input logic clk,
	input logic arst_n,
	input logic sel,
	input bus_pkg::bus_beat_t beat,
	output logic ack,
	output logic [bus_pkg::data_w-1:0] rdata
);

	import bus_pkg::*;

	logic [data_w-1:0] mem [0:(1 << addr_w)-1];
	logic [data_w-1:0] rdata_q;

	// wait counter
	logic active;
	logic [wait_cnt_w-1:0] cnt;
	logic ack_q;

	// access completes here, ack shows the next cycle
	// beat stays stable on the bus until then
	logic fire;

	assign fire = (sel && (wait_states == 0)) || (active && (cnt == wait_cnt_w'(1)));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			active <= 1'b0;
			cnt <= '0;
			ack_q <= 1'b0;
		end else begin
			ack_q <= fire;
			if (sel && (wait_states != 0)) begin
				active <= 1'b1;
				cnt <= wait_cnt_w'(wait_states);
			end else if (active) begin
				cnt <= cnt - 1'b1;
				if (cnt == wait_cnt_w'(1)) begin
					active <= 1'b0;
				end
			end
		end
	end

	// write commits at the ack, read data registered with it
	always_ff @(posedge clk) begin
		if (fire) begin
			if (beat.write) begin
				mem[beat.addr] <= beat.data;
			end else begin
				rdata_q <= mem[beat.addr];
			end
		end
	end

	assign ack = ack_q;
	assign rdata = rdata_q;

endmodule

`default_nettype wire

// File: design/slave_decoder.sv
/* slave decoder and return path */

`timescale 1ns/1ps
`default_nettype none

module slave_decoder (
	input bus_pkg::bus_beat_t beat,
	input logic beat_valid,
	input logic clk,
	input logic arst_n,
	output logic [bus_pkg::num_slaves-1:0] sel,
	input logic [bus_pkg::num_slaves-1:0] slave_ack,
	input logic [bus_pkg::num_slaves-1:0][bus_pkg::data_w-1:0] slave_rdata,
	output logic ack,
	output logic [bus_pkg::data_w-1:0] rdata,
	output logic bad_sel
);

	import bus_pkg::*;

	// error responder state
	logic bad_q;

	// one-hot select, pulse follows beat_valid
	always_comb begin
		sel = '0;
		for (int i = 0; i < num_slaves; i++) begin
			if (beat_valid && (beat.slave == slave_sel_w'(i))) begin
				sel[i] = 1'b1;
			end
		end
	end

	// unmapped select answers after one cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bad_q <= 1'b0;
		end else begin
			bad_q <= beat_valid & (beat.slave == sel_unmapped);
		end
	end

	// return mux, select is held until the ack
	always_comb begin
		rdata = err_data;
		for (int i = 0; i < num_slaves; i++) begin
			if (beat.slave == slave_sel_w'(i)) begin
				rdata = slave_rdata[i];
			end
		end
	end

	assign ack = (|slave_ack) | bad_q;
	assign bad_sel = bad_q;

endmodule

`default_nettype wire

// File: verification/bus_assertions.sv
/* bus handshake assertions */

`timescale 1ns/1ps
`default_nettype none

module bus_assertions (
	input logic clk,
	input logic arst_n,
	input logic start,
	input logic busy,
	input logic [1:0] cmd_ready,
	input logic beat_valid,
	input logic [1:0] done
);

	// burst open from its start until its done pulse
	logic burst_open;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			burst_open <= 1'b0;
		end else if (start) begin
			burst_open <= 1'b1;
		end else if (|done) begin
			burst_open <= 1'b0;
		end
	end

	// new burst only once the last one is done
	start_idle: assert property (@(posedge clk) disable iff (!arst_n)
		start |-> (!burst_open || (|done)))
		else $error("start pulse while the last burst is still open");

	// one master granted at a time, and the grant starts a burst
	ready_onehot: assert property (@(posedge clk) disable iff (!arst_n)
		(|cmd_ready) |=> busy && $onehot($past(cmd_ready)))
		else $error("cmd_ready not one-hot or the grant started no burst");

	// beats only inside a burst
	beat_in_burst: assert property (@(posedge clk) disable iff (!arst_n) beat_valid |-> busy)
		else $error("beat_valid with no burst active");

	// done is a single pulse
	done_pulse: assert property (@(posedge clk) disable iff (!arst_n) (|done) |=> !(|done))
		else $error("done held longer than one cycle");

endmodule

`default_nettype wire

// File: verification/bus_tb.sv
/* bus testbench */

`timescale 1ns/1ps
`default_nettype none

module bus_tb;

	import bus_pkg::*;

	// 14 directed commands plus random ones from both masters
	localparam int num_random = 40;
	localparam int num_cmds = 14 + 2 * num_random;
	localparam int cycle_limit = num_cmds * (16 * 5 + 4) * 2;

	// one expected read byte, known is low for never written bytes
	typedef struct packed {
		logic m;
		logic known;
		logic [7:0] val;
	} exp_read_t;

	// expected end of one burst
	typedef struct packed {
		logic m;
		logic err;
		logic [4:0] beats;
	} exp_done_t;

	logic clk = 1'b0;
	logic arst_n = 1'b0;
	logic [1:0] cmd_valid = 2'b00;
	bus_cmd_t [1:0] cmd = '0;
	logic [1:0] cmd_ready;
	bus_result_t [1:0] result;

	// reference memory of the three slaves
	logic [7:0] ref_mem [0:2][0:4095];
	bit ref_known [0:2][0:4095];
	bus_cmd_t cmd_q0 [$];
	bus_cmd_t cmd_q1 [$];
	exp_read_t read_q [$];
	exp_done_t done_q [$];
	logic [31:0] lfsr = 32'hb2f5c2a9;
	int rr_last = 1;
	int outstanding = 0;
	int rd_count = 0;
	int cycles = 0;
	int mismatches = 0;
	int other_errs = 0;
	int reads_seen = 0;
	int bursts_seen = 0;
	string test_name = "reset";

	bus_top dut0 (
		.clk(clk),
		.arst_n(arst_n),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.cmd_ready(cmd_ready),
		.result(result)
	);

	// handshake checks, unused inputs tied off
	bind bus_arbiter bus_assertions arb_chk (
		.clk(clk), .arst_n(arst_n), .start(1'b0), .busy(busy),
		.cmd_ready(cmd_ready), .beat_valid(1'b0), .done(2'b00)
	);
	bind burst_engine bus_assertions eng_chk (
		.clk(clk), .arst_n(arst_n), .start(start), .busy(busy),
		.cmd_ready(2'b00), .beat_valid(beat_valid),
		.done({result[1].done, result[0].done})
	);

	always #20 clk = ~clk;

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic queue_cmd(input int m, input logic wr, input logic [1:0] sl,
			input logic [11:0] addr, input logic [3:0] burst, input logic [7:0] data);
		bus_cmd_t c;
		c = '{write: wr, slave: sl, addr: addr, burst: burst, data: data};
		if (m == 0) begin
			cmd_q0.push_back(c);
		end else begin
			cmd_q1.push_back(c);
		end
	endtask

	// master 1 below 2048, master 2 above, never crossing the half
	task automatic queue_random(input int m);
		logic wr;
		logic [1:0] sl;
		logic [11:0] addr;
		logic [3:0] burst;
		logic [7:0] data;
		wr = 1'(take_bits(1));
		sl = 2'(take_bits(2));
		burst = 4'(take_bits(4));
		data = 8'(take_bits(8));
		addr = 12'(m * 2048 + 512) + 12'(take_bits(6));
		queue_cmd(m, wr, sl, addr, burst, data);
	endtask

	function automatic bus_cmd_t next_cmd(input int m);
		if (m == 0) begin
			return cmd_q0.pop_front();
		end
		return cmd_q1.pop_front();
	endfunction

	function automatic int queued(input int m);
		return (m == 0) ? cmd_q0.size() : cmd_q1.size();
	endfunction

	// model update at acceptance, expectations in issue order
	task automatic accept_cmd(input int m, input bus_cmd_t c, input logic both);
		logic [11:0] a;
		int s;
		s = int'(c.slave);
		if (both) begin
			// both waiting so the other master wins
			assert (m != rr_last) else begin
				mismatches++;
				$display("MISMATCH %s round robin: expected master %0d actual master %0d",
					test_name, 2 - rr_last, m + 1);
			end
		end
		rr_last = m;
		for (int i = 0; i <= int'(c.burst); i++) begin
			a = c.addr + 12'(i);
			if (s == 3) begin
				// unmapped, memory untouched
				if (!c.write) begin
					read_q.push_back(exp_read_t'{m: 1'(m), known: 1'b1, val: 8'hff});
				end
			end else if (c.write) begin
				ref_mem[s][a] = c.data;
				ref_known[s][a] = 1'b1;
			end else begin
				read_q.push_back(exp_read_t'{m: 1'(m), known: ref_known[s][a],
					val: ref_mem[s][a]});
			end
		end
		done_q.push_back(exp_done_t'{m: 1'(m), err: (s == 3),
			beats: c.write ? 5'd0 : 5'(c.burst) + 5'd1});
		outstanding++;
	endtask

	task automatic check_result(input int m, input bus_result_t r);
		exp_read_t e;
		exp_done_t d;
		assert (r == '0 || outstanding > 0) else begin
			other_errs++;
			$display("result activity on master %0d with no accepted command", m + 1);
		end
		if (r.rvalid) begin
			reads_seen++;
			rd_count++;
			assert (read_q.size() > 0) else begin
				other_errs++;
				$display("read data on master %0d that no read command asked for", m + 1);
			end
			if (read_q.size() > 0) begin
				e = read_q.pop_front();
				assert (e.m == 1'(m)) else begin
					other_errs++;
					$display("read data went to master %0d, not the command owner", m + 1);
				end
				if (e.known) begin
					assert (r.rdata == e.val) else begin
						mismatches++;
						$display("MISMATCH %s read data: expected %h actual %h",
							test_name, e.val, r.rdata);
					end
				end
			end
		end
		if (r.done) begin
			bursts_seen++;
			assert (done_q.size() > 0) else begin
				other_errs++;
				$display("done on master %0d with no burst outstanding", m + 1);
			end
			if (done_q.size() > 0) begin
				d = done_q.pop_front();
				outstanding--;
				assert (d.m == 1'(m)) else begin
					other_errs++;
					$display("done went to master %0d, not the command owner", m + 1);
				end
				assert (r.err == d.err) else begin
					mismatches++;
					$display("MISMATCH %s err at done: expected %b actual %b",
						test_name, d.err, r.err);
				end
				assert (rd_count == int'(d.beats)) else begin
					mismatches++;
					$display("MISMATCH %s read beats: expected %0d actual %0d",
						test_name, d.beats, rd_count);
				end
			end
			rd_count = 0;
		end
	endtask

	// sample before the edge updates, drive with nonblocking
	always @(posedge clk) begin
		logic both;
		both = (cmd_valid == 2'b11);
		if (!arst_n || cycles <= 2) begin
			assert ({cmd_ready, result[1].rvalid, result[1].done,
					result[0].rvalid, result[0].done} == 6'b0) else begin
				mismatches++;
				$display("MISMATCH %s idle ports: expected %b actual %b", test_name, 6'b0,
					{cmd_ready, result[1].rvalid, result[1].done,
					result[0].rvalid, result[0].done});
			end
		end
		if (arst_n) begin
			cycles++;
		end
		assert ((cmd_ready & ~cmd_valid) == 2'b00) else begin
			other_errs++;
			$display("cmd_ready given to a master without cmd_valid");
		end
		for (int m = 0; m < 2; m++) begin
			check_result(m, result[m]);
		end
		for (int m = 0; m < 2; m++) begin
			if (cmd_valid[m] && cmd_ready[m]) begin
				accept_cmd(m, cmd[m], both);
				cmd_valid[m] <= 1'b0;
			end else if (!cmd_valid[m] && queued(m) > 0) begin
				cmd[m] <= next_cmd(m);
				cmd_valid[m] <= 1'b1;
			end
		end
	end

	always @(posedge clk) begin
		if (cycles > cycle_limit) begin
			$display("timeout: bursts still open after %0d cycles", cycles);
			$display("closing: %0d reads, %0d bursts, %0d mismatches, %0d other errors",
				reads_seen, bursts_seen, mismatches, other_errs + 1);
			$display("Regression failed");
			$finish;
		end
	end

	task automatic wait_idle();
		@(negedge clk);
		while (cmd_q0.size() + cmd_q1.size() > 0 || cmd_valid != 2'b00 || outstanding > 0) begin
			@(negedge clk);
		end
	endtask

	initial begin
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		// both masters at once, master 1 first after reset
		test_name = "fill_read";
		queue_cmd(0, 1'b1, 2'd1, 12'd100, 4'd7, 8'h5a);
		queue_cmd(1, 1'b1, 2'd2, 12'd2100, 4'd7, 8'ha5);
		queue_cmd(0, 1'b0, 2'd1, 12'd100, 4'd7, 8'h00);
		queue_cmd(1, 1'b0, 2'd2, 12'd2100, 4'd7, 8'h00);
		wait_idle();
		// known fill, unmapped write, then read all four back
		test_name = "unmapped";
		for (int s = 0; s < 3; s++) begin
			queue_cmd(0, 1'b1, 2'(s), 12'd10, 4'd3, 8'h11 << s);
		end
		queue_cmd(0, 1'b1, 2'd3, 12'd10, 4'd3, 8'h33);
		for (int s = 0; s < 4; s++) begin
			queue_cmd(0, 1'b0, 2'((s + 3) % 4), 12'd10, 4'd3, 8'h00);
		end
		wait_idle();
		// 4093 through 2, read back across the wrap
		test_name = "wrap";
		queue_cmd(1, 1'b1, 2'd0, 12'd4093, 4'd5, 8'hc3);
		queue_cmd(1, 1'b0, 2'd0, 12'd4094, 4'd3, 8'h00);
		wait_idle();
		test_name = "random";
		for (int n = 0; n < num_random; n++) begin
			queue_random(0);
			queue_random(1);
		end
		wait_idle();
		$display("closing: %0d reads, %0d bursts, %0d mismatches, %0d other errors",
			reads_seen, bursts_seen, mismatches, other_errs);
		if (mismatches == 0 && other_errs == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
design/bus_pkg.sv
design/bus_arbiter.sv
design/burst_engine.sv
design/slave_decoder.sv
design/ram_slave.sv
design/bus_top.sv
verification/bus_assertions.sv
verification/bus_tb.sv
